/* Bender.yml */
package:
  name: decode_stage

sources:
  - source/decodePkg.sv
  - source/regFileBypass.sv
  - source/immExtend.sv
  - source/controlDecode.sv
  - source/branchResolve.sv
  - source/decodeStage.sv
  - target: simulation
    files:
      - sim/decodeStageTb.sv

/* sim/decodeStageTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStageTb;
    import decodePkg::*;

    logic clk = 1'b0;
    logic rstN;
    instr_t instr;
    word_t pcInc, writeData, read1Data, read2Data, imm, pcNew;
    logic writeEn, redirect, err;
    regIdx_t writeSel, rs, rt, rdOut;
    fwd_t exFwd, memFwd;
    ctl_t ctl;

    word_t shadowRegs [8];
    word_t expRead1, expRead2, expImm, expRsValue, expPcNew;
    regIdx_t expRs, expRt, expRd;
    ctl_t expCtl;
    logic expErr, expRedirect;
    logic [4:0] curOp;
    int errCount = 0;
    int cycleCount = 0;

    decodeStage u_decodeStage (
        .clk(clk), .rstN(rstN), .instr(instr), .pcInc(pcInc),
        .writeEn(writeEn), .writeSel(writeSel), .writeData(writeData),
        .exFwd(exFwd), .memFwd(memFwd), .read1Data(read1Data), .read2Data(read2Data),
        .imm(imm), .ctl(ctl), .rs(rs), .rt(rt), .rdOut(rdOut),
        .pcNew(pcNew), .redirect(redirect), .err(err)
    );

    always #20 clk = ~clk;

    // Tests take about 450 cycles
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= 600) begin
            $display("Timeout: stimulus still running after %0d cycles, %0d errors",
                     cycleCount, errCount);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic isIllegal(logic [4:0] op);
        return (op[4:1] == 4'b0001) || (op[4:2] == 3'b101);
    endfunction

    function automatic word_t expectImm(instr_t i);
        case (i.rFmt.opcode)
            ADDI, SUBI, ST, LD, STU:         return 16'($signed(i.i1Fmt.imm5));
            XORI, ANDNI:                     return 16'(i.i1Fmt.imm5);
            BEQZ, BNEZ, BLTZ, BGEZ, LBI,
            JR, JALR:                        return 16'($signed(i.i2Fmt.imm8));
            SLBI:                            return 16'(i.i2Fmt.imm8);
            J, JAL:                          return 16'($signed(i.jFmt.disp11));
            default:                         return '0;
        endcase
    endfunction

    function automatic ctl_t expectCtl(logic [4:0] op, logic [1:0] func);
        ctl_t c;
        logic i1Alu;
        logic memOp;
        logic rAlu;
        c = '0;
        i1Alu = (op[4:2] == 3'b010);
        memOp = (op == ST) || (op == LD) || (op == STU);
        rAlu = (op == SHIFT) || (op == ALU);
        if (isIllegal(op)) begin
            return c;
        end
        c.halt = (op == HALT);
        c.noOp = (op == NOP);
        // Jump group is 001xx with bit 0 for via register and bit 1 for link
        c.jump = (op[4:2] == 3'b001);
        c.jumpReg = c.jump && op[0];
        c.link = c.jump && op[1];
        c.memWrite = (op == ST) || (op == STU);
        c.memRead = (op == LD);
        c.memToReg = (op == LD);
        c.slbi = (op == SLBI);
        c.lbi = (op == LBI);
        c.btr = (op == BTR);
        c.sco = (op == SCO);
        c.aluSrc = i1Alu || memOp;
        if (i1Alu) begin
            c.aluOp = op[2:0];
        end else if (rAlu) begin
            c.aluOp = {op[0], func};
        end
        case (op)
            BEQZ: c.branchCond = COND_EQZ;
            BNEZ: c.branchCond = COND_NEZ;
            BLTZ: c.branchCond = COND_LTZ;
            BGEZ: c.branchCond = COND_GEZ;
            SEQ:  c.setCond = SET_EQ;
            SLT:  c.setCond = SET_LT;
            SLE:  c.setCond = SET_LE;
            default: ;
        endcase
        c.regWrite = i1Alu || rAlu || c.link || (op == LD) || (op == STU) || (op == LBI)
                     || (op == SLBI) || (op == BTR) || (op[4:2] == 3'b111);
        return c;
    endfunction

    function automatic regIdx_t expectRd(instr_t i);
        logic [4:0] op;
        op = i.rFmt.opcode;
        if (op == STU || op == LBI || op == SLBI) return i.i2Fmt.rs;
        if (op == JAL || op == JALR) return linkReg;
        if (op[4:3] == 2'b11) return i.rFmt.rd;
        return i[7:5];
    endfunction

    function automatic word_t forwardRs(fwd_t ex, fwd_t mem, regIdx_t sel, word_t fileVal);
        if (ex.valid && ex.rd == sel) return ex.link ? ex.pcInc : ex.data;
        if (mem.valid && mem.rd == sel) return mem.link ? mem.pcInc : mem.data;
        return fileVal;
    endfunction

    function automatic logic branchTaken(logic [4:0] op, word_t v);
        case (op)
            BEQZ:    return v == 16'h0;
            BNEZ:    return v != 16'h0;
            BLTZ:    return v[15];
            BGEZ:    return !v[15];
            default: return 1'b0;
        endcase
    endfunction

    function automatic fwd_t randomFwd();
        fwd_t f;
        f.valid = 1'($urandom());
        f.rd = 3'($urandom());
        // Zero now and then so equal-to-zero branches get taken
        f.data = ($urandom() % 4 == 0) ? 16'h0 : 16'($urandom());
        f.link = 1'($urandom());
        f.pcInc = 16'($urandom());
        return f;
    endfunction

    // Shadow copy of the register file
    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) shadowRegs[i] <= '0;
        end else if (writeEn) begin
            shadowRegs[writeSel] <= writeData;
        end
    end

    assign curOp = instr.rFmt.opcode;

    always_comb begin
        expRs = instr[10:8];
        expRt = instr[7:5];
        expRead1 = (writeEn && writeSel == expRs) ? writeData : shadowRegs[expRs];
        expRead2 = (writeEn && writeSel == expRt) ? writeData : shadowRegs[expRt];
        expImm = expectImm(instr);
        expCtl = expectCtl(curOp, instr.rFmt.func);
        expErr = isIllegal(curOp);
        expRd = expectRd(instr);
        expRsValue = forwardRs(exFwd, memFwd, expRs, expRead1);
        expPcNew = ((curOp == JR || curOp == JALR) ? expRsValue : pcInc) + expImm;
        expRedirect = branchTaken(curOp, expRsValue) || (curOp[4:2] == 3'b001);
    end

    task automatic reportMismatch(string name, logic [31:0] expected, logic [31:0] actual);
        errCount++;
        $display("ERR %s expected %h got %h", name, expected, actual);
    endtask

    property sameValue(actual, expected);
        @(negedge clk) disable iff (!rstN) actual == expected;
    endproperty

    chkRead1: assert property (sameValue(read1Data, expRead1))
        else reportMismatch("read1Data", $sampled(expRead1), $sampled(read1Data));
    chkRead2: assert property (sameValue(read2Data, expRead2))
        else reportMismatch("read2Data", $sampled(expRead2), $sampled(read2Data));
    chkImm: assert property (sameValue(imm, expImm))
        else reportMismatch("imm", $sampled(expImm), $sampled(imm));
    chkCtl: assert property (sameValue(ctl, expCtl))
        else reportMismatch("ctl", $sampled(expCtl), $sampled(ctl));
    chkErr: assert property (sameValue(err, expErr))
        else reportMismatch("err", $sampled(expErr), $sampled(err));
    chkRs: assert property (sameValue(rs, expRs))
        else reportMismatch("rs", $sampled(expRs), $sampled(rs));
    chkRt: assert property (sameValue(rt, expRt))
        else reportMismatch("rt", $sampled(expRt), $sampled(rt));
    chkRd: assert property (sameValue(rdOut, expRd))
        else reportMismatch("rdOut", $sampled(expRd), $sampled(rdOut));
    chkPcNew: assert property (sameValue(pcNew, expPcNew))
        else reportMismatch("pcNew", $sampled(expPcNew), $sampled(pcNew));
    chkRedirect: assert property (sameValue(redirect, expRedirect))
        else reportMismatch("redirect", $sampled(expRedirect), $sampled(redirect));

    task automatic applyRandom();
        @(posedge clk);
        instr <= 16'($urandom());
        pcInc <= {15'($urandom()), 1'b0};
        writeEn <= 1'($urandom());
        writeSel <= 3'($urandom());
        writeData <= 16'($urandom());
        exFwd <= randomFwd();
        memFwd <= randomFwd();
    endtask

    initial begin
        fwd_t f;
        void'($urandom(46135));
        rstN = 1'b0;
        instr = '0;
        pcInc = '0;
        writeEn = 1'b0;
        writeSel = '0;
        writeData = '0;
        exFwd = '0;
        memFwd = '0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        // Every register still at its reset value
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            instr <= {ALU, 3'(i), 3'(7 - i), 5'd0};
        end
        // Rs sees the write in flight and Rt the one before it
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            writeEn <= 1'b1;
            writeSel <= 3'(i);
            writeData <= 16'($urandom());
            instr <= {ALU, 3'(i), 3'(i - 1), 5'd0};
        end
        for (int k = 0; k < 32; k++) begin
            @(posedge clk);
            writeEn <= 1'b0;
            instr <= {5'(k), 11'($urandom())};
        end
        // Forwarding priority with all four branch conditions on r2
        for (int k = 0; k < 64; k++) begin
            @(posedge clk);
            f = randomFwd();
            f.valid = k[2];
            f.rd = k[4] ? 3'd2 : 3'd5;
            f.link = k[5];
            // Zero data so each condition sees both outcomes
            if (!k[3]) begin
                f.data = '0;
            end
            exFwd <= f;
            f = randomFwd();
            f.valid = k[3];
            f.rd = 3'd2;
            f.link = k[5];
            if (!k[4]) begin
                f.data = '0;
            end
            memFwd <= f;
            instr <= {3'b011, 2'(k), 3'd2, 8'($urandom())};
        end
        repeat (318) applyRandom();
        @(posedge clk);
        @(negedge clk);
        #1;
        $display("Checks finished after %0d cycles with %0d errors", cycleCount, errCount);
        if (errCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/branchResolve.sv */
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    input  decodePkg::word_t       rsValue,
    input  decodePkg::branchCond_t cond,
    output logic                   taken
);
    import decodePkg::*;

    logic isZero;
    logic isNeg;

    assign isZero = (rsValue == '0);
    assign isNeg  = rsValue[15];

    always_comb begin
        case (cond)
            COND_EQZ: taken = isZero;
            COND_NEZ: taken = !isZero;
            COND_LTZ: taken = isNeg;
            COND_GEZ: taken = !isNeg;
            default:  taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* source/controlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
    input  decodePkg::instr_t instr,
    output decodePkg::ctl_t   ctl,
    output logic              err
);
    import decodePkg::*;

    opcode_t op;

    assign op = instr.rFmt.opcode;

    always_comb begin
        ctl = '0;
        err = 1'b0;
        case (op)
            HALT: begin
                ctl.halt = 1'b1;
            end
            NOP: begin
                ctl.noOp = 1'b1;
            end
            J: begin
                ctl.jump = 1'b1;
            end
            JR: begin
                ctl.jump    = 1'b1;
                ctl.jumpReg = 1'b1;
            end
            JAL: begin
                ctl.jump     = 1'b1;
                ctl.link     = 1'b1;
                ctl.regWrite = 1'b1;
            end
            JALR: begin
                ctl.jump     = 1'b1;
                ctl.jumpReg  = 1'b1;
                ctl.link     = 1'b1;
                ctl.regWrite = 1'b1;
            end
            // Low opcode bits select add, sub, xor, andn
            ADDI, SUBI, XORI, ANDNI: begin
                ctl.aluOp    = instr.rFmt.opcode[2:0];
                ctl.aluSrc   = 1'b1;
                ctl.regWrite = 1'b1;
            end
            BEQZ: ctl.branchCond = COND_EQZ;
            BNEZ: ctl.branchCond = COND_NEZ;
            BLTZ: ctl.branchCond = COND_LTZ;
            BGEZ: ctl.branchCond = COND_GEZ;
            ST: begin
                ctl.aluSrc   = 1'b1;
                ctl.memWrite = 1'b1;
            end
            LD: begin
                ctl.aluSrc   = 1'b1;
                ctl.memRead  = 1'b1;
                ctl.memToReg = 1'b1;
                ctl.regWrite = 1'b1;
            end
            STU: begin
                // Store, then write the updated address back to Rs
                ctl.aluSrc   = 1'b1;
                ctl.memWrite = 1'b1;
                ctl.regWrite = 1'b1;
            end
            SLBI: begin
                ctl.slbi     = 1'b1;
                ctl.regWrite = 1'b1;
            end
            LBI: begin
                ctl.lbi      = 1'b1;
                ctl.regWrite = 1'b1;
            end
            BTR: begin
                ctl.btr      = 1'b1;
                ctl.regWrite = 1'b1;
            end
            // Shift ops get opcode bit 0 clear, arithmetic ops get it set
            SHIFT, ALU: begin
                ctl.aluOp    = {instr.rFmt.opcode[0], instr.rFmt.func};
                ctl.regWrite = 1'b1;
            end
            SEQ: begin
                ctl.setCond  = SET_EQ;
                ctl.regWrite = 1'b1;
            end
            SLT: begin
                ctl.setCond  = SET_LT;
                ctl.regWrite = 1'b1;
            end
            SLE: begin
                ctl.setCond  = SET_LE;
                ctl.regWrite = 1'b1;
            end
            SCO: begin
                ctl.sco      = 1'b1;
                ctl.regWrite = 1'b1;
            end
            default: begin
                err = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* source/decodePkg.sv */
`default_nettype none

package decodePkg;

    localparam int numRegs = 8;

    // Destination of JAL and JALR
    localparam logic [2:0] linkReg = 3'd7;

    typedef logic [2:0]  regIdx_t;
    typedef logic [15:0] word_t;
    typedef logic [2:0]  aluOp_t;

    typedef enum logic [4:0] {
        HALT  = 5'b00000, NOP   = 5'b00001,
        J     = 5'b00100, JR    = 5'b00101, JAL   = 5'b00110, JALR  = 5'b00111,
        ADDI  = 5'b01000, SUBI  = 5'b01001, XORI  = 5'b01010, ANDNI = 5'b01011,
        BEQZ  = 5'b01100, BNEZ  = 5'b01101, BLTZ  = 5'b01110, BGEZ  = 5'b01111,
        ST    = 5'b10000, LD    = 5'b10001, SLBI  = 5'b10010, STU   = 5'b10011,
        LBI   = 5'b11000, BTR   = 5'b11001, SHIFT = 5'b11010, ALU   = 5'b11011,
        SEQ   = 5'b11100, SLT   = 5'b11101, SLE   = 5'b11110, SCO   = 5'b11111
    } opcode_t;

    typedef enum logic [2:0] {
        COND_NONE, COND_EQZ, COND_NEZ, COND_LTZ, COND_GEZ
    } branchCond_t;

    // Comparison done by SEQ, SLT and SLE
    typedef enum logic [1:0] {
        SET_NONE, SET_EQ, SET_LT, SET_LE
    } setCond_t;

    // Instruction formats, all sharing the opcode in bits 15:11
    typedef struct packed {
        opcode_t    opcode;
        regIdx_t    rs;
        regIdx_t    rt;
        regIdx_t    rd;
        logic [1:0] func;
    } rFmt_t;

    typedef struct packed {
        opcode_t    opcode;
        regIdx_t    rs;
        regIdx_t    rd;
        logic [4:0] imm5;
    } i1Fmt_t;

    typedef struct packed {
        opcode_t    opcode;
        regIdx_t    rs;
        logic [7:0] imm8;
    } i2Fmt_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [10:0] disp11;
    } jFmt_t;

    typedef union packed {
        rFmt_t  rFmt;
        i1Fmt_t i1Fmt;
        i2Fmt_t i2Fmt;
        jFmt_t  jFmt;
    } instr_t;

    typedef struct packed {
        aluOp_t      aluOp;
        logic        aluSrc;
        logic        regWrite;
        logic        memWrite;
        logic        memRead;
        logic        memToReg;
        branchCond_t branchCond;
        logic        jump;
        logic        jumpReg;
        logic        link;
        logic        btr;
        logic        lbi;
        logic        slbi;
        setCond_t    setCond;
        logic        sco;
        logic        halt;
        logic        noOp;
    } ctl_t;

    // Result bundle of one later pipeline stage
    typedef struct packed {
        logic    valid;
        regIdx_t rd;
        word_t   data;
        logic    link;
        word_t   pcInc;
    } fwd_t;

endpackage

`default_nettype wire

/* source/decodeStage.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic               clk,
    input  logic               rstN,
    input  decodePkg::instr_t  instr,
    input  decodePkg::word_t   pcInc,
    input  logic               writeEn,
    input  decodePkg::regIdx_t writeSel,
    input  decodePkg::word_t   writeData,
    input  decodePkg::fwd_t    exFwd,
    input  decodePkg::fwd_t    memFwd,
    output decodePkg::word_t   read1Data,
    output decodePkg::word_t   read2Data,
    output decodePkg::word_t   imm,
    output decodePkg::ctl_t    ctl,
    output decodePkg::regIdx_t rs,
    output decodePkg::regIdx_t rt,
    output decodePkg::regIdx_t rdOut,
    output decodePkg::word_t   pcNew,
    output logic               redirect,
    output logic               err
);
    import decodePkg::*;

    opcode_t op;
    word_t   rsValue;
    word_t   targetBase;
    logic    taken;

    // A stage hits when it writes the register we read
    function automatic logic fwdHit(fwd_t f, regIdx_t sel);
        return f.valid && (f.rd == sel);
    endfunction

    // Linking stages write their return address, not their ALU result
    function automatic word_t fwdValue(fwd_t f);
        return f.link ? f.pcInc : f.data;
    endfunction

    assign op = instr.rFmt.opcode;
    assign rs = instr.rFmt.rs;
    assign rt = instr.rFmt.rt;

    regFileBypass u_regFile (
        .clk       (clk),
        .rstN      (rstN),
        .read1Sel  (rs),
        .read2Sel  (rt),
        .writeSel  (writeSel),
        .writeData (writeData),
        .writeEn   (writeEn),
        .read1Data (read1Data),
        .read2Data (read2Data)
    );

    immExtend u_immExtend (
        .instr (instr),
        .imm   (imm)
    );

    controlDecode u_controlDecode (
        .instr (instr),
        .ctl   (ctl),
        .err   (err)
    );

    always_comb begin
        case (op)
            STU, LBI, SLBI: rdOut = instr.rFmt.rs;
            JAL, JALR:      rdOut = linkReg;
            default: begin
                if (op[4:3] == 2'b11) begin
                    rdOut = instr.rFmt.rd;
                end else begin
                    rdOut = instr.i1Fmt.rd;
                end
            end
        endcase
    end

    // Youngest producer wins
    always_comb begin
        if (fwdHit(exFwd, rs)) begin
            rsValue = fwdValue(exFwd);
        end else if (fwdHit(memFwd, rs)) begin
            rsValue = fwdValue(memFwd);
        end else begin
            rsValue = read1Data;
        end
    end

    branchResolve u_branchResolve (
        .rsValue (rsValue),
        .cond    (ctl.branchCond),
        .taken   (taken)
    );

    assign targetBase = ctl.jumpReg ? rsValue : pcInc;
    assign pcNew      = targetBase + imm;
    assign redirect   = taken | ctl.jump;

endmodule

`default_nettype wire

/* source/immExtend.sv */
`timescale 1ns/1ps
`default_nettype none

module immExtend (
    input  decodePkg::instr_t instr,
    output decodePkg::word_t  imm
);
    import decodePkg::*;

    opcode_t    op;
    logic [4:0] imm5;
    logic [7:0] imm8;
    logic [10:0] disp11;

    assign op     = instr.rFmt.opcode;
    assign imm5   = instr.i1Fmt.imm5;
    assign imm8   = instr.i2Fmt.imm8;
    assign disp11 = instr.jFmt.disp11;

    always_comb begin
        case (op)
            ADDI, SUBI, ST, LD, STU:
                imm = {{11{imm5[4]}}, imm5};
            // Logical immediates stay unsigned
            XORI, ANDNI:
                imm = {11'b0, imm5};
            BEQZ, BNEZ, BLTZ, BGEZ, LBI, JR, JALR:
                imm = {{8{imm8[7]}}, imm8};
            SLBI:
                imm = {8'b0, imm8};
            J, JAL:
                imm = {{5{disp11[10]}}, disp11};
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/regFileBypass.sv */
`timescale 1ns/1ps
`default_nettype none

module regFileBypass (
    input  logic              clk,
    input  logic              rstN,
    input  decodePkg::regIdx_t read1Sel,
    input  decodePkg::regIdx_t read2Sel,
    input  decodePkg::regIdx_t writeSel,
    input  decodePkg::word_t   writeData,
    input  logic              writeEn,
    output decodePkg::word_t   read1Data,
    output decodePkg::word_t   read2Data
);
    import decodePkg::*;

    word_t regs [numRegs];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeSel] <= writeData;
        end
    end

    // Write in the same cycle passes straight through to the readers
    assign read1Data = (writeEn && (writeSel == read1Sel)) ? writeData : regs[read1Sel];
    assign read2Data = (writeEn && (writeSel == read2Sel)) ? writeData : regs[read2Sel];

endmodule

`default_nettype wire

/* sources.f */
source/decodePkg.sv
source/regFileBypass.sv
source/immExtend.sv
source/controlDecode.sv
source/branchResolve.sv
source/decodeStage.sv
sim/decodeStageTb.sv
